//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= lsu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/lsu_tb.sv
/* load/store unit testbench
   bus memory model with random grant and rvalid delays, address generator
   stand-in, directed and random accesses checked against a shadow memory */
`timescale 1ns/1ns

module lsu_tb;
  import lsu_pkg::*;

  localparam int MEM_BYTES = 1024;
  localparam int MAX_WAIT  = 60;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_size_e   lsu_type_i;
  lsu_word_t   lsu_wdata_i, adder_result_ex_i, lsu_rdata_o, addr_last_o;
  logic        lsu_rdata_valid_o, lsu_resp_valid_o, lsu_req_done_o, addr_incr_req_o;
  logic        load_err_o, store_err_o, load_o, busy_o;
  logic        data_req_o, data_we_o, data_gnt_i, data_rvalid_i, data_err_i;
  lsu_word_t   data_addr_o, data_wdata_o, data_rdata_i;
  lsu_be_t     data_be_o;

  logic [31:0] lfsr_q = 32'd75827;
  logic [7:0]  mem [MEM_BYTES];
  logic [7:0]  shadow [MEM_BYTES];
  lsu_word_t   rsp_data [$];
  logic        rsp_err [$];
  int          rsp_dly [$];
  int          gnt_wait;
  lsu_word_t   req_addr;

  always #50 clk_i = ~clk_i;

  // core stand-in, second part address keeps the byte offset
  assign adder_result_ex_i = addr_incr_req_o ? req_addr + 32'd4 : req_addr;

  lsu_top uut (.*);

  //////////////////////////////////////////////////
  // random numbers and failure reports
  //////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    stop_run();
  endtask

  //////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////

  task automatic accept_request();
    int          wa;
    logic        err;
    logic [31:0] word;
    wa  = int'(data_addr_o) & (MEM_BYTES - 1);
    // words with address bit 8 set answer with an error
    err = data_addr_o[8];
    for (int i = 0; i < 4; i++) begin
      if (data_we_o && !err && data_be_o[i]) begin
        mem[wa+i] = data_wdata_o[8*i +: 8];
      end
      word[8*i +: 8] = mem[wa+i];
    end
    rsp_data.push_back(word);
    rsp_err.push_back(err);
    rsp_dly.push_back(1 + int'(rand_bits(2) % 3));
    gnt_wait = int'(rand_bits(2) % 3);
  endtask

  always begin
    @(negedge clk_i);
    data_gnt_i = (gnt_wait == 0);
    if (gnt_wait > 0) begin
      gnt_wait--;
    end
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    // in-order responses, only the oldest counts down
    if (rsp_dly.size() > 0) begin
      if (rsp_dly[0] > 1) begin
        rsp_dly[0] = rsp_dly[0] - 1;
      end else begin
        void'(rsp_dly.pop_front());
        data_rvalid_i = 1'b1;
        data_err_i    = rsp_err.pop_front();
        data_rdata_i  = rsp_data.pop_front();
      end
    end
    // sample late in the cycle where the request is settled
    #40;
    if (rst_ni && data_req_o && data_gnt_i) begin
      accept_request();
    end
  end

  //////////////////////////////////////////////////
  // access stimulus and checks
  //////////////////////////////////////////////////

  task automatic check_idle();
    #40;
    assert (!busy_o) else mismatch("busy_o", busy_o, 0);
    assert (!data_req_o) else mismatch("data_req_o", data_req_o, 0);
    assert (!lsu_resp_valid_o) else mismatch("lsu_resp_valid_o", lsu_resp_valid_o, 0);
    assert (!addr_incr_req_o) else mismatch("addr_incr_req_o", addr_incr_req_o, 0);
    assert (!load_err_o) else mismatch("load_err_o", load_err_o, 0);
    assert (!store_err_o) else mismatch("store_err_o", store_err_o, 0);
  endtask

  task automatic run_access(input lsu_word_t addr, input int sz, input logic we,
                            input logic sext, input lsu_word_t wdata);
    int        n;
    int        grants;
    int        cyc;
    logic      split, err0, err1, err_any, done;
    logic      last_gnt;
    lsu_word_t base, next_w, exp_data, exp_addr;
    n      = (sz == 0) ? 4 : (sz == 1) ? 2 : 1;
    base   = addr & ~32'd3;
    next_w = base + 32'd4;
    split  = ((sz == 0) && (addr[1:0] != 2'b00)) || ((sz == 1) && (addr[1:0] == 2'b11));
    err0   = base[8];
    err1   = split & next_w[8];
    err_any = err0 | err1;
    // expected load value from the shadow bytes
    exp_data = '0;
    for (int k = 0; k < n; k++) begin
      exp_data[8*k +: 8] = shadow[(addr + k) & (MEM_BYTES - 1)];
    end
    if (sext && (n < 4) && exp_data[8*n-1]) begin
      exp_data = exp_data | (~32'd0 << (8 * n));
    end
    @(negedge clk_i);
    req_addr       = addr;
    lsu_we_i       = we;
    lsu_type_i     = lsu_size_e'(2'(sz));
    lsu_sign_ext_i = sext;
    lsu_wdata_i    = wdata;
    lsu_req_i      = 1'b1;
    grants = 0;
    cyc    = 0;
    done   = 1'b0;
    while (!done) begin
      #40;
      // done flags only the grant that completes the request side
      last_gnt = data_req_o && data_gnt_i && (grants == (split ? 1 : 0));
      assert (lsu_req_done_o == last_gnt)
        else mismatch("lsu_req_done_o", lsu_req_done_o, last_gnt);
      if (data_req_o && data_gnt_i) begin
        exp_addr = base + 32'(4 * grants);
        assert (data_addr_o[1:0] == 2'b00) else mismatch("data_addr_o", data_addr_o, exp_addr);
        assert (data_addr_o == exp_addr) else mismatch("data_addr_o", data_addr_o, exp_addr);
        grants++;
      end
      if (lsu_resp_valid_o) begin
        done = 1'b1;
        assert (grants == (split ? 2 : 1)) else mismatch("grant count", grants, split ? 2 : 1);
        assert (load_err_o == (err_any & ~we)) else mismatch("load_err_o", load_err_o, err_any & ~we);
        assert (store_err_o == (err_any & we)) else mismatch("store_err_o", store_err_o, err_any & we);
        assert (lsu_rdata_valid_o == (!err_any && !we))
          else mismatch("lsu_rdata_valid_o", lsu_rdata_valid_o, !err_any && !we);
        assert (load_o == !we) else mismatch("load_o", load_o, !we);
        if (!we && !err_any) begin
          assert (lsu_rdata_o == exp_data) else mismatch("lsu_rdata_o", lsu_rdata_o, exp_data);
        end
        if (err_any) begin
          exp_addr = err0 ? addr : addr + 32'd4;
          assert (addr_last_o == exp_addr) else mismatch("addr_last_o", addr_last_o, exp_addr);
        end
        assert (rsp_dly.size() == 0) else mismatch("pending responses", rsp_dly.size(), 0);
      end else begin
        assert (!load_err_o && !store_err_o && !lsu_rdata_valid_o)
          else mismatch("error or rdata valid without response",
                        {load_err_o, store_err_o, lsu_rdata_valid_o}, 0);
      end
      @(negedge clk_i);
      // first part granted, the request is no longer needed
      if (grants > 0) begin
        lsu_req_i = 1'b0;
      end
      cyc++;
      if (cyc > MAX_WAIT) begin
        $display("%0t timeout: access to %h got no response", $time, addr);
        stop_run();
      end
    end
    check_idle();
    // store bytes land only in words without an error
    if (we) begin
      for (int k = 0; k < n; k++) begin
        next_w = addr + k;
        if (!next_w[8]) begin
          shadow[next_w & (MEM_BYTES - 1)] = wdata[8*k +: 8];
        end
      end
    end
  endtask

  initial begin
    lsu_word_t a;
    int        sz;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_type_i     = SIZE_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_wdata_i    = '0;
    req_addr       = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_err_i     = 1'b0;
    data_rdata_i   = '0;
    gnt_wait       = 0;
    // fill pattern over the whole byte address
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i]    = 8'((i * 13) ^ (i >> 5));
      shadow[i] = mem[i];
    end
    rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    check_idle();
    assert (addr_last_o == '0) else mismatch("addr_last_o", addr_last_o, 0);

    // every size, offset, direction and extension, then read back as words
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off++) begin
        for (int w = 0; w < 2; w++) begin
          for (int x = 0; x < 2; x++) begin
            a = (rand_bits(7) & ~32'd3) | 32'(off);
            run_access(a, s, w[0], x[0], rand_bits(32));
            if (w == 1) begin
              run_access(a & ~32'd3, 0, 1'b0, 1'b0, '0);
              run_access((a & ~32'd3) + 32'd4, 0, 1'b0, 1'b0, '0);
            end
          end
        end
      end
    end

    // split accesses where only the second or only the first word fails
    for (int off = 1; off < 4; off++) begin
      run_access(32'd252 + 32'(off), 0, off[0], 1'b0, rand_bits(32));
      run_access(32'd508 + 32'(off), 0, off[1], 1'b0, rand_bits(32));
    end
    run_access(32'd255, 1, 1'b0, 1'b1, '0);
    run_access(32'd511, 1, 1'b1, 1'b0, rand_bits(32));

    // random accesses over the whole model, error words included
    repeat (300) begin
      sz = int'(rand_bits(2) % 3);
      a  = rand_bits(10);
      run_access(a, sz, next_bit(), next_bit(), rand_bits(32));
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- design/lsu_defs.svh
/* lsu width definitions
   word, byte-lane and in-word offset widths shared by the load/store unit */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// address and data word width
`define LSU_ADDR_W 32

// byte lanes per bus word
`define LSU_BE_W 4

// byte offset inside one word
`define LSU_OFF_W 2

`endif

//--- design/lsu_load_align.sv
/* lsu load alignment
   keeps the control of the load in flight and the first part of a split
   load, realigns the bus word and zero- or sign-extends it */
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_load_align (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ctrl_update_i,
  input  logic                 rdata_update_i,
  input  logic                 lsu_sign_ext_i,
  input  lsu_pkg::lsu_size_e   lsu_type_i,
  input  lsu_pkg::lsu_offset_t offset_i,
  input  lsu_pkg::lsu_word_t   data_rdata_i,
  output lsu_pkg::lsu_word_t   lsu_rdata_o
);
  import lsu_pkg::*;

  lsu_size_e   type_q;
  lsu_offset_t offset_q;
  logic        sign_ext_q;

  // upper three bytes of the first part
  logic [`LSU_ADDR_W-1:8]   rdata_q;
  logic [2*`LSU_ADDR_W-9:0] join_span;
  logic [2*`LSU_ADDR_W-9:0] join_shift;
  lsu_word_t                joined;
  lsu_word_t                shifted;
  logic [15:0]              half_val;
  logic [7:0]               byte_val;

  //////////////////////////////////////////////////
  // access registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      type_q     <= SIZE_WORD;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      type_q     <= lsu_type_i;
      offset_q   <= offset_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  // first-part data of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[`LSU_ADDR_W-1:8];
    end
  end

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  // second word above the saved bytes, lowest saved byte is lane 1
  assign join_span  = {data_rdata_i, rdata_q};
  // skip the saved bytes below the offset
  assign join_shift = join_span >> {offset_q - 2'd1, 3'b000};
  assign joined     = join_shift[`LSU_ADDR_W-1:0];

  // single-word access, bytes from the offset moved down to lane 0
  assign shifted = data_rdata_i >> {offset_q, 3'b000};

  // only a half-word at offset 3 spans two words
  assign half_val = (offset_q == 2'b11) ? joined[15:0] : shifted[15:0];
  assign byte_val = shifted[7:0];

  //////////////////////////////////////////////////
  // size select and extension
  //////////////////////////////////////////////////

  always_comb begin
    case (type_q)
      SIZE_WORD: begin
        // aligned word comes straight from the bus
        lsu_rdata_o = (offset_q == 2'b00) ? data_rdata_i : joined;
      end
      SIZE_HALF: begin
        lsu_rdata_o = {{16{sign_ext_q & half_val[15]}}, half_val};
      end
      // byte and the unused size code
      default: begin
        lsu_rdata_o = {{24{sign_ext_q & byte_val[7]}}, byte_val};
      end
    endcase
  end

endmodule

//--- design/lsu_pkg.sv
/* lsu shared types
   word, byte-enable, offset and access-size types of the load/store unit */
`include "lsu_defs.svh"

package lsu_pkg;

  // one address or one data word
  typedef logic [`LSU_ADDR_W-1:0] lsu_word_t;

  // one enable bit per byte lane
  typedef logic [`LSU_BE_W-1:0] lsu_be_t;

  // byte position inside a word
  typedef logic [`LSU_OFF_W-1:0] lsu_offset_t;

  // access size as given by the execute stage
  // the unused code 2'b11 behaves as a byte access
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

endpackage

//--- design/lsu_sequencer.sv
/* lsu access sequencer
   FSM that issues bus requests, splits misaligned accesses into two
   word requests, tracks bus errors and holds the last issued address */
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_sequencer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_size_e lsu_type_i,
  input  lsu_pkg::lsu_word_t addr_i,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,
  output logic               data_req_o,
  output logic               addr_incr_req_o,
  output logic               lsu_req_done_o,
  output logic               lsu_resp_valid_o,
  output logic               lsu_rdata_valid_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               load_o,
  output logic               busy_o,
  output logic               ctrl_update_o,
  output logic               rdata_update_o,
  output logic               handle_misaligned_o,
  output lsu_pkg::lsu_word_t addr_last_o
);
  import lsu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_state_e;

  ls_state_e   state_q, state_d;
  lsu_offset_t offset;
  logic        split_access;
  logic        handle_mis_q, handle_mis_d;
  logic        err_q, err_d;
  logic        we_q;
  logic        addr_update;
  logic        ctrl_update;
  logic        rdata_update;
  logic        resp_err;
  lsu_word_t   addr_last_q;

  assign offset = addr_i[`LSU_OFF_W-1:0];

  // word at any nonzero offset or half-word at offset 3 crosses a word
  assign split_access = ((lsu_type_i == SIZE_WORD) && (offset != 2'b00)) ||
                        ((lsu_type_i == SIZE_HALF) && (offset == 2'b11));

  //////////////////////////////////////////////////
  // access FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    handle_mis_d    = handle_mis_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update     = 1'b0;
    rdata_update    = 1'b0;

    case (state_q)
      IDLE: begin
        if (lsu_req_i) begin
          // request goes out in the same cycle
          data_req_o = 1'b1;
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update  = 1'b1;
            addr_update  = 1'b1;
            handle_mis_d = split_access;
            state_d      = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        // first part still held under back-pressure
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update  = 1'b1;
          addr_update  = 1'b1;
          handle_mis_d = 1'b1;
          state_d      = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second part out, core supplies the next word address
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d        = data_err_i;
          rdata_update = ~we_q;
          // keep the first failing address for the trap value
          addr_update  = data_gnt_i & ~data_err_i;
          handle_mis_d = ~data_gnt_i;
          state_d      = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          state_d      = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        // aligned request or second part of a split one
        data_req_o      = 1'b1;
        addr_incr_req_o = handle_mis_q;
        if (data_gnt_i) begin
          // second part keeps the size and offset of the first
          ctrl_update  = ~handle_mis_q;
          addr_update  = ~err_q;
          handle_mis_d = 1'b0;
          state_d      = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        // both grants taken, waiting on the first response
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d        = data_err_i;
          addr_update  = ~data_err_i;
          rdata_update = ~we_q;
          state_d      = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // last grant of the access taken this cycle
  assign lsu_req_done_o = data_req_o & data_gnt_i &
                          ((state_d == IDLE) | (state_d == WAIT_RVALID_MIS_GNTS_DONE));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      handle_mis_q <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      state_q      <= state_d;
      handle_mis_q <= handle_mis_d;
      err_q        <= err_d;
    end
  end

  // store flag of the access in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_update) begin
      we_q <= lsu_we_i;
    end
  end

  // address of the last granted part
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_i;
    end
  end

  //////////////////////////////////////////////////
  // responses to the core
  //////////////////////////////////////////////////

  // final response only arrives back in idle
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == IDLE);
  assign resp_err          = err_q | data_err_i;
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & resp_err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & resp_err & we_q;

  assign load_o              = ~we_q;
  assign busy_o              = (state_q != IDLE);
  assign ctrl_update_o       = ctrl_update;
  assign rdata_update_o      = rdata_update;
  assign handle_misaligned_o = handle_mis_q;
  assign addr_last_o         = addr_last_q;

endmodule

//--- design/lsu_store_align.sv
/* lsu store alignment
   byte-enable generation and write-data lane rotation for stores */
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_store_align (
  input  lsu_pkg::lsu_size_e  lsu_type_i,
  input  lsu_pkg::lsu_offset_t offset_i,
  input  logic                handle_misaligned_i,
  input  lsu_pkg::lsu_word_t  lsu_wdata_i,
  output lsu_pkg::lsu_be_t    data_be_o,
  output lsu_pkg::lsu_word_t  data_wdata_o
);
  import lsu_pkg::*;

  lsu_be_t                  size_mask;
  logic [2*`LSU_BE_W-1:0]   be_span;
  logic [2*`LSU_ADDR_W-1:0] wdata_span;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  // lanes covered by the access when it starts at lane 0
  always_comb begin
    case (lsu_type_i)
      SIZE_WORD: size_mask = 4'b1111;
      SIZE_HALF: size_mask = 4'b0011;
      // byte and the unused size code
      default:   size_mask = 4'b0001;
    endcase
  end

  // shift over two words so lanes past lane 3 land in the upper half
  assign be_span = {{`LSU_BE_W{1'b0}}, size_mask} << offset_i;

  // first part takes the lanes from the offset upward
  // second part takes the wrapped low lanes
  assign data_be_o = handle_misaligned_i ? be_span[2*`LSU_BE_W-1:`LSU_BE_W]
                                         : be_span[`LSU_BE_W-1:0];

  //////////////////////////////////////////////////
  // write data
  //////////////////////////////////////////////////

  // rotate left by offset bytes, store byte k goes to lane (offset + k) mod 4
  // the same rotation serves both parts of a split store
  assign wdata_span = {lsu_wdata_i, lsu_wdata_i} << {offset_i, 3'b000};

  // upper word of the doubled span holds the rotated data
  assign data_wdata_o = wdata_span[2*`LSU_ADDR_W-1:`LSU_ADDR_W];

endmodule

//--- design/lsu_top.sv
/* load/store unit top level
   joins the sequencer and the store and load aligners to the core and
   the request/grant/rvalid data bus */
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // core side
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_size_e lsu_type_i,
  input  lsu_pkg::lsu_word_t lsu_wdata_i,
  input  logic               lsu_sign_ext_i,
  input  lsu_pkg::lsu_word_t adder_result_ex_i,
  output lsu_pkg::lsu_word_t lsu_rdata_o,
  output logic               lsu_rdata_valid_o,
  output logic               lsu_resp_valid_o,
  output logic               lsu_req_done_o,
  output logic               addr_incr_req_o,
  output lsu_pkg::lsu_word_t addr_last_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               load_o,
  output logic               busy_o,
  // data bus
  output logic               data_req_o,
  output lsu_pkg::lsu_word_t data_addr_o,
  output logic               data_we_o,
  output lsu_pkg::lsu_be_t   data_be_o,
  output lsu_pkg::lsu_word_t data_wdata_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,
  input  lsu_pkg::lsu_word_t data_rdata_i
);
  import lsu_pkg::*;

  logic        ctrl_update;
  logic        rdata_update;
  logic        handle_misaligned;
  // core gives addr_last + 4 for a second part, so the offset stays put
  lsu_offset_t offset;

  assign offset      = adder_result_ex_i[`LSU_OFF_W-1:0];
  // bus only sees word addresses
  assign data_addr_o = {adder_result_ex_i[`LSU_ADDR_W-1:`LSU_OFF_W], {`LSU_OFF_W{1'b0}}};
  assign data_we_o   = lsu_we_i;

  lsu_sequencer u_sequencer (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .lsu_req_i           (lsu_req_i),
    .lsu_we_i            (lsu_we_i),
    .lsu_type_i          (lsu_type_i),
    .addr_i              (adder_result_ex_i),
    .data_gnt_i          (data_gnt_i),
    .data_rvalid_i       (data_rvalid_i),
    .data_err_i          (data_err_i),
    .data_req_o          (data_req_o),
    .addr_incr_req_o     (addr_incr_req_o),
    .lsu_req_done_o      (lsu_req_done_o),
    .lsu_resp_valid_o    (lsu_resp_valid_o),
    .lsu_rdata_valid_o   (lsu_rdata_valid_o),
    .load_err_o          (load_err_o),
    .store_err_o         (store_err_o),
    .load_o              (load_o),
    .busy_o              (busy_o),
    .ctrl_update_o       (ctrl_update),
    .rdata_update_o      (rdata_update),
    .handle_misaligned_o (handle_misaligned),
    .addr_last_o         (addr_last_o)
  );

  // store lanes
  lsu_store_align u_store_align (
    .lsu_type_i          (lsu_type_i),
    .offset_i            (offset),
    .handle_misaligned_i (handle_misaligned),
    .lsu_wdata_i         (lsu_wdata_i),
    .data_be_o           (data_be_o),
    .data_wdata_o        (data_wdata_o)
  );

  // load realignment
  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_type_i     (lsu_type_i),
    .offset_i       (offset),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

//--- tb.f
+incdir+design
design/lsu_pkg.sv
design/lsu_sequencer.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_top.sv
bench/lsu_tb.sv
